//--- Bender.yml
package:
  name: periph_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/periph_pkg.sv
      - source/bus_to_reg.sv
      - source/reg_demux.sv
      - source/irq_ctrl.sv
      - source/gpio_ctrl.sv
      - source/tick_timer.sv
      - source/periph_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/periph_tb.sv

//--- build.f
+incdir+source
source/periph_pkg.sv
source/bus_to_reg.sv
source/reg_demux.sv
source/irq_ctrl.sv
source/gpio_ctrl.sv
source/tick_timer.sv
source/periph_subsystem.sv
test/periph_tb.sv

//--- source/bus_to_reg.sv
/* Every request is granted on arrival; the register bus must answer in the
   same cycle. rvalid follows gnt by exactly one clock, no back-pressure. */
`timescale 1ns/1ps

module bus_to_reg (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::bus_req_t bus_req_i,
  output periph_pkg::bus_rsp_t bus_rsp_o,
  output periph_pkg::reg_req_t reg_req_o,
  input  periph_pkg::reg_rsp_t reg_rsp_i
);

  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  always_comb begin
    reg_req_o.valid    = bus_req_i.req;
    reg_req_o.write    = bus_req_i.we;
    reg_req_o.addr.raw = bus_req_i.addr[11:0];
    reg_req_o.wdata    = bus_req_i.wdata;
    reg_req_o.wstrb    = bus_req_i.be;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        err_q <= reg_rsp_i.error;
      end
    end
  end

  // Captured along with the grant
  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= reg_rsp_i.rdata;
    end
  end

  always_comb begin
    bus_rsp_o.gnt    = bus_req_i.req;
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.err    = err_q;
    bus_rsp_o.rdata  = rdata_q;
  end

  // No response without a grant one cycle earlier
  rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    bus_rsp_o.rvalid |-> $past(bus_rsp_o.gnt)
  );

endmodule

//--- source/gpio_ctrl.sv
/* Pins pass a two-flop synchronizer before IN and the edge detector.
   Rising-edge status is sticky until cleared by writing one. */
`timescale 1ns/1ps
`include "periph_settings.svh"

module gpio_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  periph_pkg::reg_req_t      reg_req_i,
  output periph_pkg::reg_rsp_t      reg_rsp_o,
  input  logic [`PERIPH_GPIO_W-1:0] gpio_i,
  output logic [`PERIPH_GPIO_W-1:0] gpio_o,
  output logic [`PERIPH_GPIO_W-1:0] gpio_oe_o,
  output logic [`PERIPH_GPIO_W-1:0] gpio_irq_o
);

  logic [`PERIPH_GPIO_W-1:0] out_q;
  logic [`PERIPH_GPIO_W-1:0] oe_q;
  logic [`PERIPH_GPIO_W-1:0] sync1_q;
  logic [`PERIPH_GPIO_W-1:0] sync2_q;
  logic [`PERIPH_GPIO_W-1:0] prev_q;
  logic [`PERIPH_GPIO_W-1:0] intr_en_q;
  logic [`PERIPH_GPIO_W-1:0] status_q;
  logic [`PERIPH_GPIO_W-1:0] wbits;
  logic [`PERIPH_GPIO_W-1:0] wmask;
  logic [`PERIPH_GPIO_W-1:0] rise;
  logic [5:0]                reg_idx;
  logic                      wr_en;

  assign reg_idx = reg_req_i.addr.f.idx;
  assign wr_en   = reg_req_i.valid & reg_req_i.write;
  assign wmask   = `PERIPH_GPIO_W'(periph_pkg::strb_to_mask(reg_req_i.wstrb));
  assign wbits   = reg_req_i.wdata[`PERIPH_GPIO_W-1:0];
  assign rise    = sync2_q & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && reg_idx == 6'd0) out_q <= (out_q & ~wmask) | (wbits & wmask);
      if (wr_en && reg_idx == 6'd1) oe_q <= (oe_q & ~wmask) | (wbits & wmask);
      if (wr_en && reg_idx == 6'd3) intr_en_q <= (intr_en_q & ~wmask) | (wbits & wmask);
      // New edges win over a clear in the same cycle
      if (wr_en && reg_idx == 6'd4) status_q <= (status_q & ~(wbits & wmask)) | rise;
      else status_q <= status_q | rise;
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (reg_idx)
      6'd0:    reg_rsp_o.rdata = 32'(out_q);
      6'd1:    reg_rsp_o.rdata = 32'(oe_q);
      6'd2:    reg_rsp_o.rdata = 32'(sync2_q);
      6'd3:    reg_rsp_o.rdata = 32'(intr_en_q);
      6'd4:    reg_rsp_o.rdata = 32'(status_q);
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign gpio_irq_o = status_q & intr_en_q;

endmodule

//--- source/irq_ctrl.sv
/* Level interrupt gateway without priorities: the lowest pending enabled
   source wins a claim. Source 0 means none and must be tied low outside. */
`timescale 1ns/1ps
`include "periph_settings.svh"

module irq_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  periph_pkg::reg_req_t       reg_req_i,
  output periph_pkg::reg_rsp_t       reg_rsp_o,
  input  logic [`PERIPH_NUM_IRQ-1:0] irq_src_i,
  output logic                       irq_o,
  output logic                       msip_o
);

  logic [`PERIPH_NUM_IRQ-1:0]  enable_q;
  logic [`PERIPH_NUM_IRQ-1:0]  pending_q;
  logic [`PERIPH_NUM_IRQ-1:0]  in_service_q;
  logic                        msip_q;
  logic [`PERIPH_NUM_IRQ-1:0]  active;
  logic [`PERIPH_NUM_IRQ-1:0]  claim_set;
  logic [`PERIPH_NUM_IRQ-1:0]  complete_clr;
  logic [`PERIPH_IRQ_ID_W-1:0] claim_id;
  logic [5:0]                  reg_idx;
  logic [31:0]                 wmask;
  logic                        wr_en;
  logic                        rd_claim;

  assign reg_idx  = reg_req_i.addr.f.idx;
  assign wmask    = periph_pkg::strb_to_mask(reg_req_i.wstrb);
  assign wr_en    = reg_req_i.valid & reg_req_i.write;
  assign rd_claim = reg_req_i.valid & ~reg_req_i.write & (reg_idx == 6'd2);
  assign active   = pending_q & enable_q;

  // Scan down so the lowest active source is kept
  always_comb begin
    claim_id = '0;
    for (int i = `PERIPH_NUM_IRQ - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = `PERIPH_IRQ_ID_W'(i);
      end
    end
  end

  assign claim_set = (rd_claim && active != '0) ? (`PERIPH_NUM_IRQ'(1) << claim_id) : '0;
  assign complete_clr = (wr_en && reg_idx == 6'd2 && reg_req_i.wstrb[0]) ?
                        (`PERIPH_NUM_IRQ'(1) << reg_req_i.wdata[`PERIPH_IRQ_ID_W-1:0]) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q     <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
    end else begin
      // A source already in service cannot pend again until completed
      pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_set;
      in_service_q <= (in_service_q | claim_set) & ~complete_clr;
      if (wr_en && reg_idx == 6'd0) begin
        enable_q <= (enable_q & ~wmask[`PERIPH_NUM_IRQ-1:0]) |
                    (reg_req_i.wdata[`PERIPH_NUM_IRQ-1:0] & wmask[`PERIPH_NUM_IRQ-1:0]);
      end
      if (wr_en && reg_idx == 6'd3 && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_idx)
      6'd0:    reg_rsp_o.rdata = 32'(enable_q);
      6'd1:    reg_rsp_o.rdata = 32'(pending_q);
      6'd2:    reg_rsp_o.rdata = 32'(claim_id);
      6'd3:    reg_rsp_o.rdata = {31'b0, msip_q};
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

  // Source 0 is reserved for "nothing to claim"
  src0_never_pending: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !pending_q[0]
  );

endmodule

//--- source/periph_pkg.sv
/* Bus and register bus types for the peripheral subsystem.
   Only the low 12 address bits reach the register bus. */
package periph_pkg;

  // Slave port request
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Slave port response
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic [3:0] slot;
    logic [5:0] idx;
    logic [1:0] offset;
  } reg_addr_fields_t;

  // Same 12 bits, raw for the bridge or split for the decoders
  typedef union packed {
    logic [11:0]      raw;
    reg_addr_fields_t f;
  } reg_addr_u;

  typedef struct packed {
    logic        valid;
    logic        write;
    reg_addr_u   addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Expands byte strobes into a bit mask
  function automatic logic [31:0] strb_to_mask(logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

endpackage

//--- source/periph_settings.svh
/* Sizes, slot numbers and interrupt source numbers for the whole subsystem.
   Source 0 is reserved and must stay tied to zero. */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define PERIPH_GPIO_W        8
`define PERIPH_NUM_EXT_IRQ   6
`define PERIPH_NUM_IRQ       16
`define PERIPH_IRQ_ID_W      4

// Interrupt source map
`define PERIPH_GPIO_IRQ_BASE 1
`define PERIPH_TIMER_IRQ     9
`define PERIPH_EXT_IRQ_BASE  10

// Register bus slots, decoded from address bits 11..8
`define PERIPH_SLOT_IRQ      0
`define PERIPH_SLOT_GPIO     1
`define PERIPH_SLOT_TIMER    2
`define PERIPH_NUM_SLOTS     3

`endif

//--- source/periph_subsystem.sv
/* Peripheral subsystem behind one request/grant/valid slave port.
   Slot in address bits 11..8; upper address bits are not decoded. */
`timescale 1ns/1ps
`include "periph_settings.svh"

module periph_subsystem (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  periph_pkg::bus_req_t          bus_req_i,
  output periph_pkg::bus_rsp_t          bus_rsp_o,
  input  logic [`PERIPH_NUM_EXT_IRQ-1:0] irq_ext_i,
  output logic                          irq_o,
  output logic                          msip_o,
  input  logic [`PERIPH_GPIO_W-1:0]     gpio_i,
  output logic [`PERIPH_GPIO_W-1:0]     gpio_o,
  output logic [`PERIPH_GPIO_W-1:0]     gpio_oe_o,
  output logic                          timer_irq_o
);

  periph_pkg::reg_req_t      periph_req;
  periph_pkg::reg_rsp_t      periph_rsp;
  periph_pkg::reg_req_t      irq_req;
  periph_pkg::reg_rsp_t      irq_rsp;
  periph_pkg::reg_req_t      gpio_req;
  periph_pkg::reg_rsp_t      gpio_rsp;
  periph_pkg::reg_req_t      timer_req;
  periph_pkg::reg_rsp_t      timer_rsp;
  logic [`PERIPH_GPIO_W-1:0] gpio_irq;
  logic [`PERIPH_NUM_IRQ-1:0] irq_src;

  // Source 0 stays low, it reads as "no interrupt" on a claim
  assign irq_src[0] = 1'b0;
  assign irq_src[`PERIPH_GPIO_IRQ_BASE +: `PERIPH_GPIO_W] = gpio_irq;
  assign irq_src[`PERIPH_TIMER_IRQ] = timer_irq_o;
  assign irq_src[`PERIPH_EXT_IRQ_BASE +: `PERIPH_NUM_EXT_IRQ] = irq_ext_i;

  bus_to_reg bus_to_reg_i (
    .clk_i,
    .arst_n_i,
    .bus_req_i,
    .bus_rsp_o,
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i   (periph_req),
    .reg_rsp_o   (periph_rsp),
    .irq_req_o   (irq_req),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .irq_rsp_i   (irq_rsp),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp)
  );

  irq_ctrl irq_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i (irq_req),
    .reg_rsp_o (irq_rsp),
    .irq_src_i (irq_src),
    .irq_o,
    .msip_o
  );

  gpio_ctrl gpio_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i  (gpio_req),
    .reg_rsp_o  (gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_irq_o (gpio_irq)
  );

  tick_timer tick_timer_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i (timer_req),
    .reg_rsp_o (timer_rsp),
    .timer_irq_o
  );

endmodule

//--- source/reg_demux.sv
/* Routes register accesses by the slot field. Slots beyond the mapped ones
   answer error with zero data, and their writes are dropped. */
`timescale 1ns/1ps
`include "periph_settings.svh"

module reg_demux (
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output periph_pkg::reg_req_t irq_req_o,
  output periph_pkg::reg_req_t gpio_req_o,
  output periph_pkg::reg_req_t timer_req_o,
  input  periph_pkg::reg_rsp_t irq_rsp_i,
  input  periph_pkg::reg_rsp_t gpio_rsp_i,
  input  periph_pkg::reg_rsp_t timer_rsp_i
);

  logic [3:0]                   slot;
  logic [`PERIPH_NUM_SLOTS-1:0] sel;

  assign slot = reg_req_i.addr.f.slot;

  always_comb begin
    sel                     = '0;
    sel[`PERIPH_SLOT_IRQ]   = (slot == `PERIPH_SLOT_IRQ);
    sel[`PERIPH_SLOT_GPIO]  = (slot == `PERIPH_SLOT_GPIO);
    sel[`PERIPH_SLOT_TIMER] = (slot == `PERIPH_SLOT_TIMER);
  end

  // Payload goes everywhere, valid only to the selected slot
  always_comb begin
    irq_req_o         = reg_req_i;
    irq_req_o.valid   = reg_req_i.valid & sel[`PERIPH_SLOT_IRQ];
    gpio_req_o        = reg_req_i;
    gpio_req_o.valid  = reg_req_i.valid & sel[`PERIPH_SLOT_GPIO];
    timer_req_o       = reg_req_i;
    timer_req_o.valid = reg_req_i.valid & sel[`PERIPH_SLOT_TIMER];
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b1;
    case (slot)
      `PERIPH_SLOT_IRQ:   reg_rsp_o = irq_rsp_i;
      `PERIPH_SLOT_GPIO:  reg_rsp_o = gpio_rsp_i;
      `PERIPH_SLOT_TIMER: reg_rsp_o = timer_rsp_i;
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = 1'b1;
      end
    endcase
  end

  // Never more than one peripheral sees an access
  one_target: assert final (
    $onehot0({irq_req_o.valid, gpio_req_o.valid, timer_req_o.valid})
  );

endmodule

//--- source/tick_timer.sv
/* 32-bit counter, wraps silently. The interrupt is a level that stays high
   while COUNT >= COMPARE; raise COMPARE or rewrite COUNT to drop it. */
`timescale 1ns/1ps

module tick_timer (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 timer_irq_o
);

  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic        cnt_en_q;
  logic        irq_en_q;
  logic [31:0] wmask;
  logic [5:0]  reg_idx;
  logic        wr_en;

  assign reg_idx = reg_req_i.addr.f.idx;
  assign wr_en   = reg_req_i.valid & reg_req_i.write;
  assign wmask   = periph_pkg::strb_to_mask(reg_req_i.wstrb);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      cnt_en_q  <= 1'b0;
      irq_en_q  <= 1'b0;
    end else begin
      // Software write takes the place of the increment
      if (wr_en && reg_idx == 6'd0) begin
        count_q <= (count_q & ~wmask) | (reg_req_i.wdata & wmask);
      end else if (cnt_en_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && reg_idx == 6'd1) begin
        compare_q <= (compare_q & ~wmask) | (reg_req_i.wdata & wmask);
      end
      if (wr_en && reg_idx == 6'd2 && reg_req_i.wstrb[0]) begin
        cnt_en_q <= reg_req_i.wdata[0];
        irq_en_q <= reg_req_i.wdata[1];
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (reg_idx)
      6'd0:    reg_rsp_o.rdata = count_q;
      6'd1:    reg_rsp_o.rdata = compare_q;
      6'd2:    reg_rsp_o.rdata = {30'b0, irq_en_q, cnt_en_q};
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_irq_o = irq_en_q & (count_q >= compare_q);

endmodule

//--- test/periph_tb.sv
/* Directed tests for the peripheral subsystem through its slave port.
   Stops at the first mismatch; random data comes from a fixed seed. */
`timescale 1ns/1ps
`include "periph_settings.svh"

module periph_tb;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  // Rough cycle budget per test with the timer poll the longest
  localparam int TEST_CYCLES = 120 + 120 + 300 + 200 + 80;
  localparam int TIMEOUT_NS = (RESET_CYCLES + 2 * TEST_CYCLES) * CLK_PERIOD + 1000;
  localparam int TIMER_POLL_MAX = 200;

  // Register addresses with the slot in bits 11..8
  localparam logic [31:0] IRQ_ENABLE = 32'h000;
  localparam logic [31:0] IRQ_PENDING = 32'h004;
  localparam logic [31:0] IRQ_CLAIM = 32'h008;
  localparam logic [31:0] IRQ_MSIP = 32'h00C;
  localparam logic [31:0] GPIO_OUT = 32'h100;
  localparam logic [31:0] GPIO_OE = 32'h104;
  localparam logic [31:0] GPIO_IN = 32'h108;
  localparam logic [31:0] GPIO_INTR_EN = 32'h10C;
  localparam logic [31:0] GPIO_STATUS = 32'h110;
  localparam logic [31:0] TMR_COUNT = 32'h200;
  localparam logic [31:0] TMR_COMPARE = 32'h204;
  localparam logic [31:0] TMR_CTRL = 32'h208;
  localparam logic [31:0] UNMAPPED = 32'h500;

  logic                              clk_i;
  logic                              arst_n_i;
  periph_pkg::bus_req_t              bus_req_i;
  periph_pkg::bus_rsp_t              bus_rsp_o;
  logic [`PERIPH_NUM_EXT_IRQ-1:0]    irq_ext_i;
  logic                              irq_o;
  logic                              msip_o;
  logic [`PERIPH_GPIO_W-1:0]         gpio_i;
  logic [`PERIPH_GPIO_W-1:0]         gpio_o;
  logic [`PERIPH_GPIO_W-1:0]         gpio_oe_o;
  logic                              timer_irq_o;

  periph_subsystem dut0 (
    .clk_i,
    .arst_n_i,
    .bus_req_i,
    .bus_rsp_o,
    .irq_ext_i,
    .irq_o,
    .msip_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .timer_irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped by the watchdog");
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // One access; returns the response captured with rvalid
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk_i);
    #1;
    bus_req_i.req = 1'b1;
    bus_req_i.we = we;
    bus_req_i.addr = addr;
    bus_req_i.wdata = wdata;
    bus_req_i.be = be;
    #1;
    check("rvalid before grant", bus_rsp_o.rvalid, 1'b0);
    while (!bus_rsp_o.gnt) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    bus_req_i.req = 1'b0;
    check("rvalid one cycle after gnt", bus_rsp_o.rvalid, 1'b1);
    rdata = bus_rsp_o.rdata;
    err = bus_rsp_o.err;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] unused;
    logic        err;
    bus_access(1'b1, addr, data, be, unused, err);
    check("write err", err, 1'b0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    bus_access(1'b0, addr, 32'h0, 4'hF, data, err);
  endtask

  task automatic read_expect(input string what, input logic [31:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    bus_read(addr, data, err);
    check({what, " err"}, err, 1'b0);
    check(what, data, exp);
  endtask

  task automatic test_register_access();
    logic [31:0] out_val;
    logic [31:0] oe_val;
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    out_val = $urandom & 32'hFF;
    oe_val = $urandom & 32'hFF;
    bus_write(GPIO_OUT, out_val, 4'hF);
    check("gpio_o", gpio_o, out_val);
    bus_write(GPIO_OE, oe_val, 4'hF);
    check("gpio_oe_o", gpio_oe_o, oe_val);
    read_expect("OUT readback", GPIO_OUT, out_val);
    read_expect("OE readback", GPIO_OE, oe_val);
    // Partial strobes on a full-width register
    cmp_a = $urandom;
    cmp_b = $urandom;
    bus_write(TMR_COMPARE, cmp_a, 4'hF);
    bus_write(TMR_COMPARE, cmp_b, 4'b0101);
    read_expect("COMPARE partial be", TMR_COMPARE,
                {cmp_a[31:24], cmp_b[23:16], cmp_a[15:8], cmp_b[7:0]});
    // Read then write on consecutive cycles
    @(posedge clk_i);
    #1;
    bus_req_i = '{req: 1'b1, we: 1'b0, be: 4'hF, addr: GPIO_OUT, wdata: 32'h0};
    #1;
    check("b2b first gnt", bus_rsp_o.gnt, 1'b1);
    @(posedge clk_i);
    #1;
    bus_req_i = '{req: 1'b1, we: 1'b1, be: 4'hF, addr: GPIO_OE, wdata: ~oe_val & 32'hFF};
    #1;
    check("b2b read rvalid", bus_rsp_o.rvalid, 1'b1);
    check("b2b read data", bus_rsp_o.rdata, out_val);
    check("b2b second gnt", bus_rsp_o.gnt, 1'b1);
    @(posedge clk_i);
    #1;
    bus_req_i.req = 1'b0;
    check("b2b write rvalid", bus_rsp_o.rvalid, 1'b1);
    check("b2b write err", bus_rsp_o.err, 1'b0);
    check("gpio_oe_o after b2b", gpio_oe_o, ~oe_val & 32'hFF);
  endtask

  task automatic test_gpio_input();
    logic [7:0]  pattern;
    int          k;
    logic [31:0] data;
    logic        err;
    pattern = $urandom;
    @(posedge clk_i);
    #1;
    gpio_i = pattern;
    // The read below samples IN on the third edge after the pins change
    wait_cycles(1);
    read_expect("IN", GPIO_IN, pattern);
    gpio_i = '0;
    wait_cycles(4);
    bus_write(GPIO_STATUS, 32'hFF, 4'hF);
    read_expect("STATUS cleared", GPIO_STATUS, 32'h0);
    k = $urandom % `PERIPH_GPIO_W;
    bus_write(GPIO_INTR_EN, 32'h1 << k, 4'hF);
    bus_write(IRQ_ENABLE, 32'h1 << (`PERIPH_GPIO_IRQ_BASE + k), 4'hF);
    check("irq_o before edge", irq_o, 1'b0);
    gpio_i[k] = 1'b1;
    wait_cycles(6);
    read_expect("STATUS after edge", GPIO_STATUS, 32'h1 << k);
    check("irq_o on gpio edge", irq_o, 1'b1);
    bus_read(IRQ_CLAIM, data, err);
    check("gpio claim", data, `PERIPH_GPIO_IRQ_BASE + k);
    bus_write(GPIO_STATUS, 32'h1 << k, 4'hF);
    bus_write(IRQ_CLAIM, `PERIPH_GPIO_IRQ_BASE + k, 4'hF);
    wait_cycles(2);
    check("irq_o after complete", irq_o, 1'b0);
    gpio_i = '0;
    bus_write(GPIO_INTR_EN, 32'h0, 4'hF);
  endtask

  task automatic test_timer();
    logic [31:0] cmp;
    logic [31:0] data;
    logic        err;
    int          n;
    cmp = 20 + ($urandom % 30);
    bus_write(TMR_COMPARE, cmp, 4'hF);
    bus_write(TMR_COUNT, 32'h0, 4'hF);
    bus_write(IRQ_ENABLE, 32'h1 << `PERIPH_TIMER_IRQ, 4'hF);
    bus_write(TMR_CTRL, 32'h3, 4'hF);
    n = 0;
    while (!timer_irq_o && n < TIMER_POLL_MAX) begin
      wait_cycles(1);
      n++;
    end
    if (!timer_irq_o) begin
      $display("The timer interrupt never rose after %0d cycles", TIMER_POLL_MAX);
      $display("TEST FAIL");
      $fatal(1, "timer interrupt missing");
    end
    bus_read(TMR_COUNT, data, err);
    check("COUNT at least COMPARE", data >= cmp, 1'b1);
    bus_read(IRQ_CLAIM, data, err);
    check("timer claim", data, `PERIPH_TIMER_IRQ);
    bus_write(TMR_COMPARE, 32'hFFFF_0000, 4'hF);
    check("timer_irq_o after raising COMPARE", timer_irq_o, 1'b0);
    bus_write(IRQ_CLAIM, `PERIPH_TIMER_IRQ, 4'hF);
    bus_write(TMR_CTRL, 32'h0, 4'hF);
    wait_cycles(2);
    check("irq_o after timer complete", irq_o, 1'b0);
  endtask

  task automatic test_lowest_first();
    logic [`PERIPH_NUM_EXT_IRQ-1:0] raised;
    logic [`PERIPH_NUM_EXT_IRQ-1:0] enabled;
    logic [31:0]                    en_word;
    logic [31:0]                    data;
    logic                           err;
    raised = 6'b011011;
    // Input 0 stays disabled
    enabled = 6'b011010;
    en_word = 32'(enabled) << `PERIPH_EXT_IRQ_BASE;
    bus_write(IRQ_ENABLE, en_word, 4'hF);
    @(posedge clk_i);
    #1;
    irq_ext_i = raised;
    wait_cycles(3);
    read_expect("PENDING ext", IRQ_PENDING, 32'(raised) << `PERIPH_EXT_IRQ_BASE);
    for (int i = 0; i < `PERIPH_NUM_EXT_IRQ; i++) begin
      if (enabled[i]) begin
        check("irq_o with enabled pending", irq_o, 1'b1);
        bus_read(IRQ_CLAIM, data, err);
        check("ascending claim", data, `PERIPH_EXT_IRQ_BASE + i);
        irq_ext_i[i] = 1'b0;
        bus_write(IRQ_CLAIM, `PERIPH_EXT_IRQ_BASE + i, 4'hF);
      end
    end
    bus_read(IRQ_CLAIM, data, err);
    check("empty claim", data, 32'h0);
    bus_read(IRQ_PENDING, data, err);
    check("disabled source pending", data[`PERIPH_EXT_IRQ_BASE], 1'b1);
    check("irq_o with only disabled pending", irq_o, 1'b0);
    irq_ext_i = '0;
  endtask

  task automatic test_errors_and_msip();
    logic [31:0] out_before;
    logic [31:0] en_before;
    logic [31:0] data;
    logic        err;
    bus_read(GPIO_OUT, out_before, err);
    bus_read(IRQ_ENABLE, en_before, err);
    bus_read(UNMAPPED, data, err);
    check("unmapped read err", err, 1'b1);
    check("unmapped read data", data, 32'h0);
    bus_access(1'b1, UNMAPPED, ~out_before, 4'hF, data, err);
    check("unmapped write err", err, 1'b1);
    check("unmapped write data", data, 32'h0);
    read_expect("OUT after unmapped write", GPIO_OUT, out_before);
    read_expect("ENABLE after unmapped write", IRQ_ENABLE, en_before);
    bus_write(IRQ_MSIP, 32'h1, 4'hF);
    check("msip_o set", msip_o, 1'b1);
    read_expect("MSIP readback", IRQ_MSIP, 32'h1);
    bus_write(IRQ_MSIP, 32'h0, 4'hF);
    check("msip_o cleared", msip_o, 1'b0);
  endtask

  initial begin
    void'($urandom(97));
    arst_n_i = 1'b0;
    bus_req_i = '0;
    irq_ext_i = '0;
    gpio_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check("rvalid after reset", bus_rsp_o.rvalid, 1'b0);
    check("irq_o after reset", irq_o, 1'b0);
    check("msip_o after reset", msip_o, 1'b0);
    check("timer_irq_o after reset", timer_irq_o, 1'b0);
    check("gpio_oe_o after reset", gpio_oe_o, 32'h0);
    check("gpio_o after reset", gpio_o, 32'h0);
    test_register_access();
    test_gpio_input();
    test_timer();
    test_lowest_first();
    test_errors_and_msip();
    $display("TEST PASS");
    $finish;
  end

endmodule
